//--- src.f
rtl/eng_bus_pkg.sv
rtl/eng_conf_pkg.sv
rtl/eng_ctrl.sv
rtl/eng_mem.sv
rtl/eng_alu.sv
rtl/eng_mul.sv
rtl/eng_rd_mux.sv
rtl/data_eng.sv
tb/data_eng_tb.sv

//--- Makefile
# Verilator build and run for the data engine testbench

VERILATOR ?= verilator
TOP       ?= data_eng_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/data_eng_tb.sv
// Data engine testbench, table-driven with a reference model and a watchdog
`default_nettype none

module data_eng_tb
   import eng_bus_pkg::*;
   import eng_conf_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD    = 8;
   localparam int STEP_CYCLES   = 200;
   localparam int READY_TIMEOUT = 64;
   localparam int MEM_WORDS     = 2**MEM_ADDR_W;

   typedef enum logic [2:0] {ST_CTR_WR, ST_DB_WR, ST_RUN, ST_WAIT, ST_READ} step_kind_e;

   // For databus steps the region field holds the memory index
   typedef struct packed {
      step_kind_e            kind;
      logic                  via_db;
      logic [REGION_W-1:0]   region;
      logic [MEM_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     data;
      logic [CONF_BITS-1:0]  conf;
   } step_t;

   logic                  rst;
   logic                  clk;
   logic                  ctr_req;
   logic                  run_req;
   logic                  ctr_rnw;
   logic [ENG_ADDR_W-1:0] ctr_addr;
   logic [DATA_W-1:0]     ctr_data_to_wr;
   logic [DATA_W-1:0]     ctr_data_to_rd;
   logic [CONF_BITS-1:0]  config_bus;
   logic                  databus_req;
   logic                  databus_rnw;
   logic [DB_ADDR_W-1:0]  databus_addr;
   logic [DATA_W-1:0]     databus_data_in;
   logic [DATA_W-1:0]     databus_data_out;
   logic                  ready;

   step_t                 steps[$];
   int                    n_steps;
   integer                seed;

   // Reference model state
   logic [DATA_W-1:0]     ref_mem [N_MEM][MEM_WORDS];
   mem_conf_t [N_MEM-1:0] run_mc;
   alu_conf_t             run_ac;
   mul_conf_t             run_uc;

   data_eng u_data_eng (
      .rst              (rst),
      .clk              (clk),
      .ctr_req          (ctr_req),
      .run_req          (run_req),
      .ctr_rnw          (ctr_rnw),
      .ctr_addr         (ctr_addr),
      .ctr_data_to_wr   (ctr_data_to_wr),
      .ctr_data_to_rd   (ctr_data_to_rd),
      .config_bus       (config_bus),
      .databus_req      (databus_req),
      .databus_rnw      (databus_rnw),
      .databus_addr     (databus_addr),
      .databus_data_in  (databus_data_in),
      .databus_data_out (databus_data_out),
      .ready            (ready)
   );

   // rst is the clock of this design
   initial begin
      rst = 1'b0;
      forever #(CLK_PERIOD / 2) rst = ~rst;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
      if (actual !== expected) begin
         fail_run($sformatf("MISMATCH at %0d ns: %s expected %h actual %h",
                            $time, name, expected, actual));
      end
   endtask

   task automatic check_ready(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         fail_run($sformatf("MISMATCH at %0d ns: %s expected %b actual %b",
                            $time, name, expected, actual));
      end
   endtask

   // Expected results, built from the generator and unit rules
   function automatic logic [DATA_W-1:0] alu_ref(input alu_fn_e fn, input logic [DATA_W-1:0] a,
                                                 input logic [DATA_W-1:0] b);
      case (fn)
         ADD:     return a + b;
         SUB:     return a - b;
         AND:     return a & b;
         OR:      return a | b;
         XOR:     return a ^ b;
         MAX:     return ($signed(a) > $signed(b)) ? a : b;
         MIN:     return ($signed(a) < $signed(b)) ? a : b;
         default: return a;
      endcase
   endfunction

   function automatic logic [DATA_W-1:0] mul_ref(input logic [DATA_W-1:0] a,
                                                 input logic [DATA_W-1:0] b, input logic hi);
      longint prod;
      prod = longint'($signed(a)) * longint'($signed(b));
      return hi ? prod[63:32] : prod[31:0];
   endfunction

   // Word shown by a read port for its k-th issued address
   function automatic logic [DATA_W-1:0] operand_word(input logic [SEL_W-1:0] sel, input int k);
      port_conf_t            pc;
      logic [MEM_ADDR_W-1:0] a;
      int                    s;
      if (sel == SEL_ZERO) begin
         return '0;
      end else if (sel == SEL_ONE) begin
         return DATA_W'(1);
      end else if (sel >= SEL_ALU) begin
         return 'x;
      end
      s  = int'(sel) - int'(SEL_MEM0A);
      pc = (s % 2 == 0) ? run_mc[s / 2].a : run_mc[s / 2].b;
      a  = pc.start + pc.incr * MEM_ADDR_W'(k);
      return ref_mem[s / 2][a];
   endfunction

   // Write ports here take a unit result, which matches a write delay of 2
   function automatic logic [DATA_W-1:0] unit_word(input logic [SEL_W-1:0] sel, input int k);
      if (sel == SEL_ALU) begin
         return alu_ref(run_ac.fn, operand_word(run_ac.sel_a, k), operand_word(run_ac.sel_b, k));
      end else if (sel == SEL_MUL) begin
         return mul_ref(operand_word(run_uc.sel_a, k), operand_word(run_uc.sel_b, k), run_uc.hi);
      end else begin
         return operand_word(sel, k);
      end
   endfunction

   function automatic void model_run();
      logic [DATA_W-1:0]     nxt [N_MEM][MEM_WORDS];
      port_conf_t            pc;
      logic [MEM_ADDR_W-1:0] a;
      nxt = ref_mem;
      for (int m = 0; m < N_MEM; m++) begin
         for (int p = 0; p < N_PORT; p++) begin
            pc = (p == 0) ? run_mc[m].a : run_mc[m].b;
            if (pc.wr_en) begin
               for (int k = 0; k < int'(pc.iter); k++) begin
                  a           = pc.start + pc.incr * MEM_ADDR_W'(k);
                  nxt[m][a]   = unit_word(pc.sel, k);
               end
            end
         end
      end
      ref_mem = nxt;
   endfunction

   function automatic port_conf_t port_cfg(input logic [MEM_ADDR_W-1:0] start,
                                           input logic [MEM_ADDR_W-1:0] incr,
                                           input logic [ITER_W-1:0] iter,
                                           input logic [DELAY_W-1:0] delay,
                                           input logic wr_en, input logic [SEL_W-1:0] sel);
      port_conf_t pc;
      pc.start = start;
      pc.incr  = incr;
      pc.iter  = iter;
      pc.delay = delay;
      pc.wr_en = wr_en;
      pc.sel   = sel;
      return pc;
   endfunction

   function automatic mem_conf_t mem_cfg(input port_conf_t pa, input port_conf_t pb);
      mem_conf_t mc;
      mc.a = pa;
      mc.b = pb;
      return mc;
   endfunction

   // Table builders keep the model in step with the stimulus
   task automatic put_write(input logic via_db, input logic [REGION_W-1:0] region,
                            input logic [MEM_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      step_t st;
      st        = '0;
      st.kind   = via_db ? ST_DB_WR : ST_CTR_WR;
      st.via_db = via_db;
      st.region = region;
      st.addr   = addr;
      st.data   = data;
      steps.push_back(st);
      ref_mem[region][addr] = data;
   endtask

   task automatic expect_read(input logic via_db, input logic [REGION_W-1:0] region,
                              input logic [MEM_ADDR_W-1:0] addr);
      step_t st;
      st        = '0;
      st.kind   = ST_READ;
      st.via_db = via_db;
      st.region = region;
      st.addr   = addr;
      if (!via_db && region == REG_RDY) begin
         st.data = DATA_W'(1);
      end else begin
         st.data = ref_mem[region][addr];
      end
      steps.push_back(st);
   endtask

   task automatic schedule_run(input mem_conf_t m0, input mem_conf_t m1, input alu_conf_t ac,
                               input mul_conf_t uc);
      step_t st;
      run_mc[0] = m0;
      run_mc[1] = m1;
      run_ac    = ac;
      run_uc    = uc;
      st        = '0;
      st.kind   = ST_RUN;
      st.conf   = {m0, m1, ac, uc};
      steps.push_back(st);
      st.kind   = ST_WAIT;
      steps.push_back(st);
      model_run();
   endtask

   task automatic build_table();
      port_conf_t idle;
      port_conf_t rd8;
      alu_conf_t  ac;
      mul_conf_t  uc;
      idle = port_cfg(4'd0, 4'd0, 5'd0, 3'd0, 1'b0, SEL_ZERO);
      rd8  = port_cfg(4'd0, 4'd1, 5'd8, 3'd0, 1'b0, SEL_ZERO);
      expect_read(1'b0, REG_RDY, '0);
      for (int m = 0; m < N_MEM; m++) begin
         for (int a = 0; a < MEM_WORDS; a++) begin
            put_write(1'b0, REGION_W'(m), MEM_ADDR_W'(a), $random(seed));
         end
      end
      for (int m = 0; m < N_MEM; m++) begin
         for (int a = 0; a < MEM_WORDS; a++) begin
            expect_read(1'b0, REGION_W'(m), MEM_ADDR_W'(a));
         end
      end
      // Databus writes, read back both ways
      for (int i = 0; i < 6; i++) begin
         put_write(1'b1, REGION_W'(i % 2), MEM_ADDR_W'(2 * i + 1), $random(seed));
      end
      for (int i = 0; i < 6; i++) begin
         expect_read(1'b1, REGION_W'(i % 2), MEM_ADDR_W'(2 * i + 1));
         expect_read(1'b0, REGION_W'(i % 2), MEM_ADDR_W'(2 * i + 1));
      end
      // One ALU run per function code
      uc = '0;
      for (int f = 0; f < 8; f++) begin
         ac.fn    = alu_fn_e'(f);
         ac.sel_a = SEL_MEM0A;
         ac.sel_b = SEL_MEM1A;
         schedule_run(mem_cfg(rd8, idle),
                      mem_cfg(rd8, port_cfg(4'd8, 4'd1, 5'd8, 3'd2, 1'b1, SEL_ALU)), ac, uc);
         for (int a = 8; a < MEM_WORDS; a++) begin
            expect_read(1'b0, REG_MEM1, MEM_ADDR_W'(a));
         end
      end
      // Multiplier, high half then low half
      ac = '0;
      for (int h = 1; h >= 0; h--) begin
         uc.sel_a = SEL_MEM0A;
         uc.sel_b = SEL_MEM1A;
         uc.hi    = (h == 1);
         schedule_run(mem_cfg(rd8, port_cfg(4'd8, 4'd1, 5'd8, 3'd2, 1'b1, SEL_MUL)),
                      mem_cfg(rd8, idle), ac, uc);
         for (int a = 8; a < MEM_WORDS; a++) begin
            expect_read(1'b1, REGION_W'(0), MEM_ADDR_W'(a));
         end
      end
      // Stride 3 with wrap, mem1 port B stays idle
      ac.fn    = ADD;
      ac.sel_a = SEL_MEM0A;
      ac.sel_b = SEL_ONE;
      uc       = '0;
      schedule_run(mem_cfg(port_cfg(4'd1, 4'd3, 5'd6, 3'd0, 1'b0, SEL_ZERO), idle),
                   mem_cfg(port_cfg(4'd2, 4'd3, 5'd6, 3'd2, 1'b1, SEL_ALU), idle), ac, uc);
      expect_read(1'b0, REG_RDY, '0);
      for (int a = 0; a < MEM_WORDS; a++) begin
         expect_read(1'b0, REG_MEM1, MEM_ADDR_W'(a));
         expect_read(1'b1, REGION_W'(0), MEM_ADDR_W'(a));
      end
   endtask

   // Bus tasks start and end on a falling edge
   task automatic ctr_access(input logic rnw, input logic [ENG_ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
      ctr_req        = 1'b1;
      ctr_rnw        = rnw;
      ctr_addr       = addr;
      ctr_data_to_wr = data;
      @(negedge rst);
      ctr_req = 1'b0;
      ctr_rnw = 1'b1;
   endtask

   task automatic db_access(input logic rnw, input logic [DB_ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
      databus_req     = 1'b1;
      databus_rnw     = rnw;
      databus_addr    = addr;
      databus_data_in = data;
      @(negedge rst);
      databus_req = 1'b0;
      databus_rnw = 1'b1;
   endtask

   task automatic run_engine(input logic [CONF_BITS-1:0] conf);
      run_req    = 1'b1;
      ctr_rnw    = 1'b0;
      config_bus = conf;
      @(negedge rst);
      run_req = 1'b0;
      ctr_rnw = 1'b1;
   endtask

   task automatic wait_ready();
      int   cycles;
      logic seen;
      cycles = 1;
      seen   = 1'b0;
      // Every run in the table has a busy port, so the first poll sees ready low
      ctr_access(1'b1, {REG_RDY, MEM_ADDR_W'(0)}, '0);
      check_ready("ready", 1'b0, ready);
      check_word("ctr_data_to_rd", DATA_W'(0), ctr_data_to_rd);
      while (!seen && cycles < READY_TIMEOUT) begin
         ctr_access(1'b1, {REG_RDY, MEM_ADDR_W'(0)}, '0);
         seen   = ctr_data_to_rd[0];
         cycles = cycles + 1;
      end
      if (!seen) begin
         fail_run("The run never finished, ready stayed low for 64 cycles");
      end else begin
         check_ready("ready", 1'b1, ready);
      end
   endtask

   task automatic apply_step(input step_t st);
      case (st.kind)
         ST_CTR_WR: ctr_access(1'b0, {st.region, st.addr}, st.data);
         ST_DB_WR:  db_access(1'b0, {st.region[MEM_IDX_W-1:0], st.addr}, st.data);
         ST_RUN:    run_engine(st.conf);
         ST_WAIT:   wait_ready();
         default: begin
            if (st.via_db) begin
               db_access(1'b1, {st.region[MEM_IDX_W-1:0], st.addr}, '0);
               check_word("databus_data_out", st.data, databus_data_out);
            end else begin
               ctr_access(1'b1, {st.region, st.addr}, '0);
               check_word("ctr_data_to_rd", st.data, ctr_data_to_rd);
            end
         end
      endcase
   endtask

   initial begin
      seed            = 32'ha11d_e572;
      n_steps         = 0;
      clk             = 1'b1;
      ctr_req         = 1'b0;
      run_req         = 1'b0;
      ctr_rnw         = 1'b1;
      ctr_addr        = '0;
      ctr_data_to_wr  = '0;
      config_bus      = '0;
      databus_req     = 1'b0;
      databus_rnw     = 1'b1;
      databus_addr    = '0;
      databus_data_in = '0;
      build_table();
      n_steps = steps.size();
      repeat (4) @(posedge rst);
      @(negedge rst);
      clk = 1'b0;
      check_ready("ready", 1'b1, ready);
      foreach (steps[i]) begin
         apply_step(steps[i]);
      end
      $display("All checks passed");
      $finish;
   end

   // Watchdog scaled by the table length
   initial begin
      wait (n_steps > 0);
      repeat ((n_steps + 1) * STEP_CYCLES) @(posedge rst);
      fail_run("Watchdog expired before the table was finished");
   end

endmodule

`default_nettype wire

//--- rtl/data_eng.sv
// Data engine top level, builds the data bus and connects all units
`default_nettype none

module data_eng
   import eng_bus_pkg::*;
   import eng_conf_pkg::*;
(
   // rst is the clock, clk the asynchronous reset
   input  logic                  rst,
   input  logic                  clk,
   input  logic                  ctr_req,
   input  logic                  run_req,
   input  logic                  ctr_rnw,
   input  logic [ENG_ADDR_W-1:0] ctr_addr,
   input  logic [DATA_W-1:0]     ctr_data_to_wr,
   output logic [DATA_W-1:0]     ctr_data_to_rd,
   input  logic [CONF_BITS-1:0]  config_bus,
   input  logic                  databus_req,
   input  logic                  databus_rnw,
   input  logic [DB_ADDR_W-1:0]  databus_addr,
   input  logic [DATA_W-1:0]     databus_data_in,
   output logic [DATA_W-1:0]     databus_data_out,
   output logic                  ready
);

   wire data_bus_t               data_bus;

   logic                         run_reg;
   mem_conf_t [N_MEM-1:0]        mem_conf;
   alu_conf_t                    alu_conf;
   mul_conf_t                    mul_conf;
   logic [N_MEM-1:0]             ctr_mem_req;
   logic [N_MEM-1:0]             db_mem_req;
   logic [REGION_W-1:0]          rd_src;
   logic [N_MEM-1:0][DATA_W-1:0] mem_a;
   logic [N_MEM-1:0][DATA_W-1:0] mem_b;
   logic [N_MEM-1:0]             mem_done;
   logic [DATA_W-1:0]            alu_res;
   logic [DATA_W-1:0]            mul_res;

   // Constant entries, everything else is a registered unit output
   assign data_bus[SEL_ZERO] = '0;
   assign data_bus[SEL_ONE]  = DATA_W'(1);
   assign data_bus[SEL_ALU]  = alu_res;
   assign data_bus[SEL_MUL]  = mul_res;

   assign ready = &mem_done;

   eng_ctrl u_ctrl (
      .rst          (rst),
      .clk          (clk),
      .ctr_req      (ctr_req),
      .run_req      (run_req),
      .ctr_rnw      (ctr_rnw),
      .ctr_addr     (ctr_addr),
      .databus_req  (databus_req),
      .databus_addr (databus_addr),
      .config_bus   (config_bus),
      .run_reg      (run_reg),
      .mem_conf     (mem_conf),
      .alu_conf     (alu_conf),
      .mul_conf     (mul_conf),
      .ctr_mem_req  (ctr_mem_req),
      .db_mem_req   (db_mem_req),
      .rd_src       (rd_src)
   );

   for (genvar i = 0; i < N_MEM; i++) begin : g_mem
      eng_mem u_mem (
         .rst            (rst),
         .clk            (clk),
         .run_reg        (run_reg),
         .conf           (mem_conf[i]),
         .data_bus       (data_bus),
         .ctr_req        (ctr_mem_req[i]),
         .ctr_rnw        (ctr_rnw),
         .ctr_addr_w     (ctr_addr[MEM_ADDR_W-1:0]),
         .ctr_data_to_wr (ctr_data_to_wr),
         .db_req         (db_mem_req[i]),
         .db_rnw         (databus_rnw),
         .db_addr_w      (databus_addr[MEM_ADDR_W-1:0]),
         .db_data_in     (databus_data_in),
         .out_a          (mem_a[i]),
         .out_b          (mem_b[i]),
         .done           (mem_done[i])
      );

      assign data_bus[SEL_MEM0A + 2*i] = mem_a[i];
      assign data_bus[SEL_MEM0B + 2*i] = mem_b[i];
   end

   eng_alu u_alu (
      .rst      (rst),
      .clk      (clk),
      .run_reg  (run_reg),
      .conf     (alu_conf),
      .data_bus (data_bus),
      .result   (alu_res)
   );

   eng_mul u_mul (
      .rst      (rst),
      .clk      (clk),
      .run_reg  (run_reg),
      .conf     (mul_conf),
      .data_bus (data_bus),
      .result   (mul_res)
   );

   eng_rd_mux u_rd_mux (
      .rst              (rst),
      .clk              (clk),
      .rd_src           (rd_src),
      .db_mem_sel       (databus_addr[DB_ADDR_W-1 -: MEM_IDX_W]),
      .mem_out_a        (mem_a),
      .mem_out_b        (mem_b),
      .ready            (ready),
      .ctr_data_to_rd   (ctr_data_to_rd),
      .databus_data_out (databus_data_out)
   );

endmodule

`default_nettype wire

//--- rtl/eng_rd_mux.sv
// Engine output side, returning controller and databus read data
`default_nettype none

module eng_rd_mux
   import eng_bus_pkg::*;
(
   input  logic                         rst,
   input  logic                         clk,
   input  logic [REGION_W-1:0]          rd_src,
   input  logic [MEM_IDX_W-1:0]         db_mem_sel,
   input  logic [N_MEM-1:0][DATA_W-1:0] mem_out_a,
   input  logic [N_MEM-1:0][DATA_W-1:0] mem_out_b,
   input  logic                         ready,
   output logic [DATA_W-1:0]            ctr_data_to_rd,
   output logic [DATA_W-1:0]            databus_data_out
);

   logic [REGION_W-1:0]  rd_src_q;
   logic [MEM_IDX_W-1:0] db_sel_q;

   // Memory outputs arrive one cycle after the request, so align the select
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         rd_src_q <= REG_MEM0;
         db_sel_q <= '0;
      end else begin
         rd_src_q <= rd_src;
         db_sel_q <= db_mem_sel;
      end
   end

   always_comb begin
      case (rd_src_q)
         REG_MEM0: ctr_data_to_rd = mem_out_a[0];
         REG_MEM1: ctr_data_to_rd = mem_out_a[1];
         REG_RDY:  ctr_data_to_rd = {{(DATA_W-1){1'b0}}, ready};
         default:  ctr_data_to_rd = '0;
      endcase
   end

   assign databus_data_out = mem_out_b[db_sel_q];

endmodule

`default_nettype wire

//--- rtl/eng_mul.sv
// Engine multiplier, signed and registered, returning the high or low half
`default_nettype none

module eng_mul
   import eng_bus_pkg::*;
   import eng_conf_pkg::*;
(
   input  logic              rst,
   input  logic              clk,
   input  logic              run_reg,
   input  mul_conf_t         conf,
   input  data_bus_t         data_bus,
   output logic [DATA_W-1:0] result
);

   logic signed [2*DATA_W-1:0] prod;

   assign prod = $signed(data_bus[conf.sel_a]) * $signed(data_bus[conf.sel_b]);

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         result <= '0;
      end else if (run_reg) begin
         result <= '0;
      end else begin
         result <= conf.hi ? prod[2*DATA_W-1:DATA_W] : prod[DATA_W-1:0];
      end
   end

endmodule

`default_nettype wire

//--- rtl/eng_alu.sv
// Engine ALU, registered, with operands selected from the data bus
`default_nettype none

module eng_alu
   import eng_bus_pkg::*;
   import eng_conf_pkg::*;
(
   input  logic              rst,
   input  logic              clk,
   input  logic              run_reg,
   input  alu_conf_t         conf,
   input  data_bus_t         data_bus,
   output logic [DATA_W-1:0] result
);

   logic [DATA_W-1:0] op_a;
   logic [DATA_W-1:0] op_b;
   logic [DATA_W-1:0] res_d;

   assign op_a = data_bus[conf.sel_a];
   assign op_b = data_bus[conf.sel_b];

   always_comb begin
      case (conf.fn)
         ADD:     res_d = op_a + op_b;
         SUB:     res_d = op_a - op_b;
         AND:     res_d = op_a & op_b;
         OR:      res_d = op_a | op_b;
         XOR:     res_d = op_a ^ op_b;
         // Signed compare for max and min
         MAX:     res_d = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
         MIN:     res_d = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
         default: res_d = op_a;
      endcase
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         result <= '0;
      end else if (run_reg) begin
         result <= '0;
      end else begin
         result <= res_d;
      end
   end

endmodule

`default_nettype wire

//--- rtl/eng_mem.sv
// Engine data memory, dual port with an address generator on each port
`default_nettype none

module eng_mem
   import eng_bus_pkg::*;
   import eng_conf_pkg::*;
(
   input  logic                  rst,
   input  logic                  clk,
   input  logic                  run_reg,
   input  mem_conf_t             conf,
   input  data_bus_t             data_bus,
   input  logic                  ctr_req,
   input  logic                  ctr_rnw,
   input  logic [MEM_ADDR_W-1:0] ctr_addr_w,
   input  logic [DATA_W-1:0]     ctr_data_to_wr,
   input  logic                  db_req,
   input  logic                  db_rnw,
   input  logic [MEM_ADDR_W-1:0] db_addr_w,
   input  logic [DATA_W-1:0]     db_data_in,
   output logic [DATA_W-1:0]     out_a,
   output logic [DATA_W-1:0]     out_b,
   output logic                  done
);

   // Per-port config and host side, port A is controller, port B is databus
   port_conf_t            pconf     [N_PORT];
   logic                  host_req  [N_PORT];
   logic                  host_rnw  [N_PORT];
   logic [MEM_ADDR_W-1:0] host_addr [N_PORT];
   logic [DATA_W-1:0]     host_din  [N_PORT];

   // Generator state
   logic [DELAY_W-1:0]    dly_cnt   [N_PORT];
   logic [ITER_W-1:0]     iter_cnt  [N_PORT];
   logic [MEM_ADDR_W-1:0] gen_addr  [N_PORT];
   logic                  port_done [N_PORT];

   // Resolved access per port
   logic                  acc_we    [N_PORT];
   logic                  acc_rd    [N_PORT];
   logic [MEM_ADDR_W-1:0] acc_addr  [N_PORT];
   logic [DATA_W-1:0]     acc_din   [N_PORT];
   logic [DATA_W-1:0]     port_out  [N_PORT];

   logic [DATA_W-1:0]     mem [2**MEM_ADDR_W];

   assign pconf[0]     = conf.a;
   assign pconf[1]     = conf.b;
   assign host_req[0]  = ctr_req;
   assign host_req[1]  = db_req;
   assign host_rnw[0]  = ctr_rnw;
   assign host_rnw[1]  = db_rnw;
   assign host_addr[0] = ctr_addr_w;
   assign host_addr[1] = db_addr_w;
   assign host_din[0]  = ctr_data_to_wr;
   assign host_din[1]  = db_data_in;

   for (genvar p = 0; p < N_PORT; p++) begin : g_port
      logic gen_act;

      // Generator owns the port once its delay has run out
      assign gen_act = !port_done[p] && (dly_cnt[p] == '0);

      always_ff @(posedge rst or posedge clk) begin
         if (clk) begin
            dly_cnt[p]   <= '0;
            iter_cnt[p]  <= '0;
            gen_addr[p]  <= '0;
            port_done[p] <= 1'b1;
         end else if (run_reg) begin
            dly_cnt[p]   <= pconf[p].delay;
            iter_cnt[p]  <= pconf[p].iter;
            gen_addr[p]  <= pconf[p].start;
            port_done[p] <= (pconf[p].iter == '0);
         end else if (!port_done[p]) begin
            if (dly_cnt[p] != '0) begin
               dly_cnt[p] <= dly_cnt[p] - 1'b1;
            end else begin
               // Address wraps modulo the memory size
               gen_addr[p]  <= gen_addr[p] + pconf[p].incr;
               iter_cnt[p]  <= iter_cnt[p] - 1'b1;
               port_done[p] <= (iter_cnt[p] == ITER_W'(1));
            end
         end
      end

      assign acc_we[p]   = gen_act ? pconf[p].wr_en : (host_req[p] & ~host_rnw[p]);
      assign acc_rd[p]   = gen_act ? ~pconf[p].wr_en : (host_req[p] & host_rnw[p]);
      assign acc_addr[p] = gen_act ? gen_addr[p] : host_addr[p];
      assign acc_din[p]  = gen_act ? data_bus[pconf[p].sel] : host_din[p];

      // Output only moves on a read so host data holds
      always_ff @(posedge rst or posedge clk) begin
         if (clk) begin
            port_out[p] <= '0;
         end else if (acc_rd[p]) begin
            port_out[p] <= mem[acc_addr[p]];
         end
      end
   end

   // Port B wins on a same-address write
   always_ff @(posedge rst) begin
      for (int p = 0; p < N_PORT; p++) begin
         if (acc_we[p]) begin
            mem[acc_addr[p]] <= acc_din[p];
         end
      end
   end

   assign out_a = port_out[0];
   assign out_b = port_out[1];
   assign done  = port_done[0] & port_done[1];

endmodule

`default_nettype wire

//--- rtl/eng_ctrl.sv
// Engine input side with run register, configuration shadow and host address decoders
`default_nettype none

module eng_ctrl
   import eng_bus_pkg::*;
   import eng_conf_pkg::*;
(
   input  logic                  rst,
   input  logic                  clk,
   input  logic                  ctr_req,
   input  logic                  run_req,
   input  logic                  ctr_rnw,
   input  logic [ENG_ADDR_W-1:0] ctr_addr,
   input  logic                  databus_req,
   input  logic [DB_ADDR_W-1:0]  databus_addr,
   input  logic [CONF_BITS-1:0]  config_bus,
   output logic                  run_reg,
   output mem_conf_t [N_MEM-1:0] mem_conf,
   output alu_conf_t             alu_conf,
   output mul_conf_t             mul_conf,
   output logic [N_MEM-1:0]      ctr_mem_req,
   output logic [N_MEM-1:0]      db_mem_req,
   output logic [REGION_W-1:0]   rd_src
);

   logic                 run;
   logic [CONF_BITS-1:0] conf_q;
   logic [REGION_W-1:0]  region;
   logic [REGION_W-1:0]  rd_region_q;
   logic [MEM_IDX_W-1:0] db_mem;

   // A run request is only valid as a write
   assign run    = run_req & ~ctr_rnw;
   assign region = ctr_addr[ENG_ADDR_W-1 -: REGION_W];
   assign db_mem = databus_addr[DB_ADDR_W-1 -: MEM_IDX_W];

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         run_reg <= 1'b0;
         conf_q  <= '0;
      end else begin
         run_reg <= run;
         if (run) begin
            conf_q <= config_bus;
         end
      end
   end

   // Remember the last read region so the read data holds
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         rd_region_q <= REG_MEM0;
      end else if (ctr_req && ctr_rnw) begin
         rd_region_q <= region;
      end
   end

   assign rd_src = (ctr_req && ctr_rnw) ? region : rd_region_q;

   // Slice the shadow into per-unit words
   assign mem_conf[0] = conf_q[CONF_MEM0_B -: MEM_CONF_W];
   assign mem_conf[1] = conf_q[CONF_MEM1_B -: MEM_CONF_W];
   assign alu_conf    = conf_q[CONF_ALU_B -: ALU_CONF_W];
   assign mul_conf    = conf_q[CONF_MUL_B -: MUL_CONF_W];

   always_comb begin
      for (int i = 0; i < N_MEM; i++) begin
         ctr_mem_req[i] = ctr_req && (region == REGION_W'(i));
         db_mem_req[i]  = databus_req && (db_mem == MEM_IDX_W'(i));
      end
   end

endmodule

`default_nettype wire

//--- rtl/eng_conf_pkg.sv
// Engine configuration package with config word layout, field widths and ALU codes
`default_nettype none

package eng_conf_pkg;

   import eng_bus_pkg::*;

   // Memory port fields
   localparam int ITER_W      = 5;
   localparam int DELAY_W     = 3;
   localparam int N_PORT      = 2;
   localparam int PORT_CONF_W = 2 * MEM_ADDR_W + ITER_W + DELAY_W + 1 + SEL_W;
   localparam int MEM_CONF_W  = N_PORT * PORT_CONF_W;

   typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, MAX, MIN, PASS} alu_fn_e;

   localparam int ALU_CONF_W = $bits(alu_fn_e) + 2 * SEL_W;
   localparam int MUL_CONF_W = 2 * SEL_W + 1;

   // Config word from the top: mem0, mem1, alu, mul
   localparam int CONF_BITS   = N_MEM * MEM_CONF_W + ALU_CONF_W + MUL_CONF_W;
   localparam int CONF_MEM0_B = CONF_BITS - 1;
   localparam int CONF_MEM1_B = CONF_MEM0_B - MEM_CONF_W;
   localparam int CONF_ALU_B  = CONF_MEM1_B - MEM_CONF_W;
   localparam int CONF_MUL_B  = CONF_ALU_B - ALU_CONF_W;

   typedef struct packed {
      logic [MEM_ADDR_W-1:0] start;
      logic [MEM_ADDR_W-1:0] incr;
      logic [ITER_W-1:0]     iter;
      logic [DELAY_W-1:0]    delay;
      logic                  wr_en;
      logic [SEL_W-1:0]      sel;
   } port_conf_t;

   typedef struct packed {
      port_conf_t a;
      port_conf_t b;
   } mem_conf_t;

   typedef struct packed {
      alu_fn_e          fn;
      logic [SEL_W-1:0] sel_a;
      logic [SEL_W-1:0] sel_b;
   } alu_conf_t;

   typedef struct packed {
      logic [SEL_W-1:0] sel_a;
      logic [SEL_W-1:0] sel_b;
      logic             hi;
   } mul_conf_t;

endpackage

`default_nettype wire

//--- rtl/eng_bus_pkg.sv
// Engine bus package with data bus layout, entry indices and host address map
`default_nettype none

package eng_bus_pkg;

   // Data word and memory geometry
   localparam int DATA_W     = 32;
   localparam int N_MEM      = 2;
   localparam int MEM_IDX_W  = $clog2(N_MEM);
   localparam int MEM_ADDR_W = 4;

   // Data bus entries
   localparam int N_SEL = 8;
   localparam int SEL_W = 3;

   localparam logic [SEL_W-1:0] SEL_ZERO  = 3'd0;
   localparam logic [SEL_W-1:0] SEL_ONE   = 3'd1;
   localparam logic [SEL_W-1:0] SEL_MEM0A = 3'd2;
   localparam logic [SEL_W-1:0] SEL_MEM0B = 3'd3;
   localparam logic [SEL_W-1:0] SEL_MEM1A = 3'd4;
   localparam logic [SEL_W-1:0] SEL_MEM1B = 3'd5;
   localparam logic [SEL_W-1:0] SEL_ALU   = 3'd6;
   localparam logic [SEL_W-1:0] SEL_MUL   = 3'd7;

   // Controller address, region on top and word below
   localparam int ENG_ADDR_W = 6;
   localparam int REGION_W   = ENG_ADDR_W - MEM_ADDR_W;

   localparam logic [REGION_W-1:0] REG_MEM0 = 2'd0;
   localparam logic [REGION_W-1:0] REG_MEM1 = 2'd1;
   localparam logic [REGION_W-1:0] REG_RDY  = 2'd2;

   // Databus address is memory index then word address
   localparam int DB_ADDR_W = MEM_IDX_W + MEM_ADDR_W;

   typedef logic [N_SEL-1:0][DATA_W-1:0] data_bus_t;

endpackage

`default_nettype wire
